/* Makefile */
# Verilator build of the link CSR block testbench

TOOL       := verilator
TOP        := tbMgtCsr
FILELIST   := tb.f
BUILD_DIR  := obj_dir
LOG        := sim.log
FLAGS      := --timing --top-module $(TOP)
LINT_FLAGS := --lint-only $(FLAGS)
SIM_FLAGS  := --binary $(FLAGS) -Mdir $(BUILD_DIR)
PASS_MSG   := Simulation finished: PASS

.PHONY: all lint sim clean

all: sim

# static checks over the whole file list
lint:
	$(TOOL) $(LINT_FLAGS) -f $(FILELIST)

# build, run, then decide on the log contents
sim:
	$(TOOL) $(SIM_FLAGS) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "result: pass"; \
	else \
		echo "result: fail"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* common/mgtCsrPkg.sv */
////////////////////////////////////////////////////////////
// register map of the link CSR block
// APB address and data widths, CSR word type, field offsets
////////////////////////////////////////////////////////////

package mgtCsrPkg;

    ////////////////////////////////////////////////////////////
    // APB bus widths

    localparam int apbAddrWidth = 12;                  // byte address
    localparam int apbDataWidth = 32;                  // read and write data

    typedef logic [apbAddrWidth-1:0] apbAddrT;         // APB address
    typedef logic [apbDataWidth-1:0] csrWordT;         // full CSR data word

    ////////////////////////////////////////////////////////////
    // register map

    // only one register lives in this block
    localparam apbAddrT csrAddr = '0;                  // byte address of the CSR

    // field placement inside the CSR word
    // bits above the control field read back as zero
    localparam int ctrlLsb   = 12;                     // control field, bits 17..12
    localparam int statusLsb = 0;                      // status field, bits 11..0

endpackage : mgtCsrPkg

/* common/mgtLinkPkg.sv */
////////////////////////////////////////////////////////////
// link side bit types
// control and status vectors, synchronizer depth
////////////////////////////////////////////////////////////

package mgtLinkPkg;

    localparam int ctrlWidth   = 6;                    // control bits to the link core
    localparam int statusWidth = 12;                   // status field incl. qualified crc

    // msb down: txPolarity txPmaReset txPcsReset gtReset linkReset powerDown
    typedef logic [ctrlWidth-1:0] ctrlBitsT;

    // msb down: hardErr softErr laneUp channelUp crcPassQual crcValid
    //           crcPass txResetDone rxResetDone mmcmNotLocked gtPllLock cpllLock
    typedef logic [statusWidth-1:0] statusBitsT;

    // status positions used by the crc qualification
    localparam int crcQualBit  = 7;                    // crcPass gated by crcValid
    localparam int crcValidBit = 6;                    // raw crc valid
    localparam int crcPassBit  = 5;                    // raw crc pass

    localparam int syncStages = 2;                     // default synchronizer depth

endpackage : mgtLinkPkg

/* common/mgtStatusIf.sv */
////////////////////////////////////////////////////////////
// status word between the sync stage and the APB slave
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface mgtStatusIf;

    import mgtLinkPkg::*;

    statusBitsT status;                                // synchronized, crc qualified

    // producer side, owned by statusSync
    modport sync (
        output status
    );

    // consumer side, owned by apbCsrSlave
    modport csr (
        input status
    );

endinterface : mgtStatusIf

/* csr/apbCsrSlave.sv */
////////////////////////////////////////////////////////////
// APB slave of the link CSR
// control register, CSR word readback, bad address error
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module apbCsrSlave (
    input  logic                 sysClk,
    input  logic                 rst,

    // APB, always ready
    input  logic                 pSel,
    input  logic                 pEnable,
    input  logic                 pWrite,
    input  mgtCsrPkg::apbAddrT   pAddr,
    input  mgtCsrPkg::csrWordT   pWdata,
    output mgtCsrPkg::csrWordT   pRdata,
    output logic                 pReady,
    output logic                 pSlvErr,

    // synchronized status from the first stage
    mgtStatusIf.csr              statusIn,

    // control bits to the link core
    output mgtLinkPkg::ctrlBitsT ctrl
);

    import mgtCsrPkg::*;
    import mgtLinkPkg::*;

    logic     accessPhase;                             // pSel and pEnable both high
    logic     addrHit;                                 // pAddr matches the CSR
    logic     goodWrite;                               // write to the CSR
    logic     goodRead;                                // read of the CSR
    ctrlBitsT ctrlReg;                                 // control register
    ctrlBitsT ctrlNext;                                // control field of pWdata
    csrWordT  csrWord;                                 // assembled readback word

    ////////////////////////////////////////////////////////////
    // transfer decode

    assign accessPhase = pSel & pEnable;
    assign addrHit     = (pAddr == csrAddr);
    assign goodWrite   = accessPhase & pWrite & addrHit;
    assign goodRead    = accessPhase & ~pWrite & addrHit;

    // no wait states
    assign pReady  = 1'b1;
    assign pSlvErr = accessPhase & ~addrHit;           // any other address errors

    ////////////////////////////////////////////////////////////
    // control register
    // loads at the edge that ends the access phase

    assign ctrlNext = pWdata[ctrlLsb +: ctrlWidth];    // rest of pWdata dropped

    always_ff @(posedge sysClk) begin
        if (rst) begin
            ctrlReg <= '0;                             // all controls released
        end else if (goodWrite) begin
            ctrlReg <= ctrlNext;
        end
    end

    assign ctrl = ctrlReg;                             // new value right after the edge

    ////////////////////////////////////////////////////////////
    // readback
    // zeros above bit 17, control 17..12, status 11..0

    always_comb begin
        csrWord                             = '0;
        csrWord[ctrlLsb +: ctrlWidth]       = ctrlReg;
        csrWord[statusLsb +: statusWidth]   = statusIn.status;
    end

    // zero outside a good read, so bad addresses return nothing
    assign pRdata = goodRead ? csrWord : '0;

endmodule : apbCsrSlave

/* src/mgtCsrTop.sv */
////////////////////////////////////////////////////////////
// top of the link CSR block
// status synchronizer stage followed by the APB register stage
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mgtCsrTop (
    input  logic               sysClk,
    input  logic               rst,

    // APB slave port
    input  logic               pSel,
    input  logic               pEnable,
    input  logic               pWrite,
    input  mgtCsrPkg::apbAddrT pAddr,
    input  mgtCsrPkg::csrWordT pWdata,
    output mgtCsrPkg::csrWordT pRdata,
    output logic               pReady,
    output logic               pSlvErr,

    // raw status from the link core, any clock
    input  logic               hardErr,
    input  logic               softErr,
    input  logic               laneUp,
    input  logic               channelUp,
    input  logic               crcValid,
    input  logic               crcPass,
    input  logic               txResetDone,
    input  logic               rxResetDone,
    input  logic               mmcmNotLocked,
    input  logic               gtPllLock,
    input  logic               cpllLock,

    // control to the link core
    output logic               powerDown,
    output logic               linkReset,
    output logic               gtReset,
    output logic               txPcsReset,
    output logic               txPmaReset,
    output logic               txPolarity
);

    import mgtLinkPkg::*;

    statusBitsT rawStatus;                             // raw lines in csr bit order
    ctrlBitsT   ctrlWord;                              // control register contents

    mgtStatusIf statusBus ();                          // stage boundary

    // bit 7 is formed after the synchronizer
    assign rawStatus = {hardErr, softErr, laneUp, channelUp,
                        1'b0, crcValid, crcPass, txResetDone,
                        rxResetDone, mmcmNotLocked, gtPllLock, cpllLock};

    statusSync #(
        .stages    (syncStages)
    ) statusSyncInst (
        .sysClk    (sysClk),
        .rst       (rst),
        .rawStatus (rawStatus),
        .statusOut (statusBus.sync)
    );

    apbCsrSlave apbCsrSlaveInst (
        .sysClk    (sysClk),
        .rst       (rst),
        .pSel      (pSel),
        .pEnable   (pEnable),
        .pWrite    (pWrite),
        .pAddr     (pAddr),
        .pWdata    (pWdata),
        .pRdata    (pRdata),
        .pReady    (pReady),
        .pSlvErr   (pSlvErr),
        .statusIn  (statusBus.csr),
        .ctrl      (ctrlWord)
    );

    assign {txPolarity, txPmaReset, txPcsReset,
            gtReset, linkReset, powerDown} = ctrlWord; // straight from the register

endmodule : mgtCsrTop

/* src/statusSync.sv */
////////////////////////////////////////////////////////////
// status synchronizer into sysClk
// flop chain per status line plus crc pass qualification
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module statusSync #(
    parameter int stages = mgtLinkPkg::syncStages      // chain depth, 1 or more
) (
    input  logic                   sysClk,
    input  logic                   rst,
    input  mgtLinkPkg::statusBitsT rawStatus,          // bit 7 not used here
    mgtStatusIf.sync               statusOut
);

    import mgtLinkPkg::*;

    statusBitsT chainIn;                               // raw lines, qual slot cleared
    statusBitsT syncReg [stages];                      // synchronizer chain
    statusBitsT syncLast;                              // last flop of the chain
    statusBitsT statusQual;                            // output word
    logic       qualPass;                              // crc pass seen as valid

    ////////////////////////////////////////////////////////////
    // chain input

    always_comb begin
        chainIn             = rawStatus;
        chainIn[crcQualBit] = 1'b0;                    // slot is rebuilt below
    end

    ////////////////////////////////////////////////////////////
    // synchronizer chain
    // first flop may go metastable, later ones settle it

    always_ff @(posedge sysClk) begin
        if (rst) begin
            for (int i = 0; i < stages; i++) begin
                syncReg[i] <= '0;                      // whole chain cleared
            end
        end else begin
            syncReg[0] <= chainIn;                     // async capture
            for (int i = 1; i < stages; i++) begin
                syncReg[i] <= syncReg[i-1];            // shift along
            end
        end
    end

    assign syncLast = syncReg[stages-1];

    ////////////////////////////////////////////////////////////
    // crc pass qualification
    // both inputs come from the same chain depth, no extra delay

    assign qualPass = syncLast[crcValidBit] ? syncLast[crcPassBit] : 1'b0;

    always_comb begin
        statusQual             = syncLast;
        statusQual[crcQualBit] = qualPass;             // pass only when valid
    end

    assign statusOut.status = statusQual;              // to the register stage

endmodule : statusSync

/* tb.f */
+incdir+testbench
common/mgtCsrPkg.sv
common/mgtLinkPkg.sv
common/mgtStatusIf.sv
src/statusSync.sv
csr/apbCsrSlave.sv
src/mgtCsrTop.sv
testbench/tbMgtCsr.sv

/* testbench/mgtCsrTasks.svh */
////////////////////////////////////////////////////////////
// APB driver tasks, LFSR source and compare tasks
// directed tests of the link CSR block
////////////////////////////////////////////////////////////

`ifndef MGT_CSR_TASKS_SVH
`define MGT_CSR_TASKS_SVH

////////////////////////////////////////////////////////////
// stimulus helpers

task automatic tick();
    @(posedge sysClk);
    #driveDelay;                                       // drive point after the edge
endtask

// fibonacci LFSR with taps 32 22 2 1 and one step per bit taken
function automatic logic [31:0] randBits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
        fb        = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
        lfsrState = {lfsrState[30:0], fb};
        v         = {v[30:0], fb};
    end
    return v;
endfunction

// lines from msb down are hardErr softErr laneUp channelUp crcValid crcPass
// txResetDone rxResetDone mmcmNotLocked gtPllLock cpllLock
task automatic driveStatus(input logic [10:0] v);
    rawLines = v;
    {hardErr, softErr, laneUp, channelUp, crcValid, crcPass,
     txResetDone, rxResetDone, mmcmNotLocked, gtPllLock, cpllLock} = v;
endtask

// status field as mapped with bit 7 as pass gated by valid
function automatic statusBitsT statusFromLines(input logic [10:0] v);
    return {v[10:7], v[6] & v[5], v[6:0]};
endfunction

// zeros on top, control 17..12, status 11..0
function automatic csrWordT expectedWord(input ctrlBitsT c, input statusBitsT s);
    return {{(apbDataWidth - ctrlWidth - statusWidth){1'b0}}, c, s};
endfunction

////////////////////////////////////////////////////////////
// compare tasks

task automatic checkWord(input string name, input csrWordT exp, input csrWordT act);
    if (act !== exp) begin
        $display("[FAIL] %0t ns %s expected %h actual %h", $time, name, exp, act);
        failRun();
    end
endtask

task automatic checkCtrl(input ctrlBitsT exp);
    ctrlBitsT act;
    act = {txPolarity, txPmaReset, txPcsReset, gtReset, linkReset, powerDown};
    if (act !== exp) begin
        $display("[FAIL] %0t ns control outputs expected %b actual %b", $time, exp, act);
        failRun();
    end
endtask

task automatic checkBit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        $display("[FAIL] %0t ns %s expected %b actual %b", $time, name, exp, act);
        failRun();
    end
endtask

////////////////////////////////////////////////////////////
// APB transfers
// both start at a drive point and end at the one after the access edge

task automatic apbWrite(input apbAddrT addr, input csrWordT data, input logic expErr);
    pSel    = 1'b1;                                    // setup phase
    pEnable = 1'b0;
    pWrite  = 1'b1;
    pAddr   = addr;
    pWdata  = data;
    tick();
    pEnable = 1'b1;                                    // access phase
    #sampleDelay;
    checkBit("pReady", 1'b1, pReady);
    checkBit("pSlvErr", expErr, pSlvErr);
    tick();
    pSel    = 1'b0;                                    // idle unless a transfer follows
    pEnable = 1'b0;
endtask

task automatic apbRead(input apbAddrT addr, input logic expErr, output csrWordT data);
    pSel    = 1'b1;
    pEnable = 1'b0;
    pWrite  = 1'b0;
    pAddr   = addr;
    tick();
    pEnable = 1'b1;
    #sampleDelay;                                      // rdata is combinational
    checkBit("pReady", 1'b1, pReady);
    checkBit("pSlvErr", expErr, pSlvErr);
    data = pRdata;
    tick();
    pSel    = 1'b0;
    pEnable = 1'b0;
endtask

////////////////////////////////////////////////////////////
// directed tests

task automatic resetValues();
    csrWordT rd;
    checkCtrl('0);
    checkBit("pSlvErr", 1'b0, pSlvErr);                // idle bus
    apbRead(csrAddr, 1'b0, rd);                        // chain still as reset left it
    checkWord("pRdata", '0, rd);
endtask

task automatic ctrlWrites(input int count);
    csrWordT wd;
    csrWordT rd;
    for (int i = 0; i < count; i++) begin
        wd = randBits(apbDataWidth);                   // junk outside 17..12 too
        apbWrite(csrAddr, wd, 1'b0);
        ctrlModel = wd[ctrlLsb +: ctrlWidth];
        checkCtrl(ctrlModel);                          // right after the access edge
        apbRead(csrAddr, 1'b0, rd);
        checkWord("pRdata", expectedWord(ctrlModel, statusFromLines(rawLines)), rd);
    end
endtask

task automatic statusMapping(input int count);
    logic [31:0] r;
    logic [10:0] lines;
    statusBitsT  prevStatus;
    csrWordT     rd;
    for (int i = 0; i < count; i++) begin
        prevStatus = statusFromLines(rawLines);
        r          = randBits(11);
        lines      = r[10:0];
        driveStatus(lines);
        repeat (syncStages - 2) tick();
        apbRead(csrAddr, 1'b0, rd);                    // one edge short
        checkWord("pRdata", expectedWord(ctrlModel, prevStatus), rd);
        r     = randBits(11);
        lines = r[10:0];
        driveStatus(lines);
        repeat (syncStages - 1) tick();
        apbRead(csrAddr, 1'b0, rd);                    // exactly syncStages edges
        checkWord("pRdata", expectedWord(ctrlModel, statusFromLines(lines)), rd);
    end
endtask

task automatic crcQualify();
    logic [31:0] r;
    logic [10:0] lines;
    csrWordT     rd;
    for (int combo = 0; combo < 4; combo++) begin
        r        = randBits(11);
        lines    = r[10:0];
        lines[6] = combo[1];                           // crcValid
        lines[5] = combo[0];                           // crcPass
        driveStatus(lines);
        repeat (syncStages - 1) tick();
        apbRead(csrAddr, 1'b0, rd);
        checkBit("qualified crc pass", combo[1] & combo[0], rd[crcQualBit]);
        checkWord("pRdata", expectedWord(ctrlModel, statusFromLines(lines)), rd);
    end
endtask

task automatic badAddress(input int count);
    logic [31:0] r;
    apbAddrT     addr;
    csrWordT     wd;
    csrWordT     rd;
    for (int i = 0; i < count; i++) begin
        r    = randBits(apbAddrWidth);
        addr = r[apbAddrWidth-1:0];
        if (addr == csrAddr) begin
            addr = 12'h004;                            // next word over
        end
        apbRead(addr, 1'b1, rd);
        checkWord("pRdata", '0, rd);
        wd = randBits(apbDataWidth);
        apbWrite(addr, wd, 1'b1);
        checkCtrl(ctrlModel);                          // nothing taken
    end
    apbRead(csrAddr, 1'b0, rd);
    checkWord("pRdata", expectedWord(ctrlModel, statusFromLines(rawLines)), rd);
endtask

task automatic backToBack(input int count);
    csrWordT wd;
    csrWordT rd;
    for (int i = 0; i < count; i++) begin
        wd = randBits(apbDataWidth);
        apbWrite(csrAddr, wd, 1'b0);
        ctrlModel = wd[ctrlLsb +: ctrlWidth];
        checkCtrl(ctrlModel);
        wd = randBits(apbDataWidth);                   // second write with no idle cycle
        apbWrite(csrAddr, wd, 1'b0);
        ctrlModel = wd[ctrlLsb +: ctrlWidth];
        checkCtrl(ctrlModel);
        apbRead(csrAddr, 1'b0, rd);
        checkWord("pRdata", expectedWord(ctrlModel, statusFromLines(rawLines)), rd);
    end
endtask

`endif

/* testbench/tbMgtCsr.sv */
////////////////////////////////////////////////////////////
// testbench of the link CSR block
// clock, reset, DUT, timeout and the directed test run
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tbMgtCsr;

    import mgtCsrPkg::*;
    import mgtLinkPkg::*;

    localparam int clkPeriod     = 40;
    localparam int driveDelay    = 2;                  // inputs move after the edge
    localparam int sampleDelay   = 10;                 // outputs read mid access cycle
    // tests need under 1500 cycles so the limit leaves twice that
    localparam int timeoutCycles = 3000;

    logic       sysClk;
    logic       rst;
    logic       pSel;
    logic       pEnable;
    logic       pWrite;
    apbAddrT    pAddr;
    csrWordT    pWdata;
    csrWordT    pRdata;
    logic       pReady;
    logic       pSlvErr;

    logic       hardErr;
    logic       softErr;
    logic       laneUp;
    logic       channelUp;
    logic       crcValid;
    logic       crcPass;
    logic       txResetDone;
    logic       rxResetDone;
    logic       mmcmNotLocked;
    logic       gtPllLock;
    logic       cpllLock;
    logic       powerDown;
    logic       linkReset;
    logic       gtReset;
    logic       txPcsReset;
    logic       txPmaReset;
    logic       txPolarity;

    logic [31:0] lfsrState = 32'hb78b_0ab2;            // random source state
    logic [10:0] rawLines;                             // status lines as driven
    ctrlBitsT    ctrlModel;                            // expected control register
    int          cycleCount = 0;

    ////////////////////////////////////////////////////////////
    // DUT

    mgtCsrTop dut (
        .sysClk        (sysClk),
        .rst           (rst),
        .pSel          (pSel),
        .pEnable       (pEnable),
        .pWrite        (pWrite),
        .pAddr         (pAddr),
        .pWdata        (pWdata),
        .pRdata        (pRdata),
        .pReady        (pReady),
        .pSlvErr       (pSlvErr),
        .hardErr       (hardErr),
        .softErr       (softErr),
        .laneUp        (laneUp),
        .channelUp     (channelUp),
        .crcValid      (crcValid),
        .crcPass       (crcPass),
        .txResetDone   (txResetDone),
        .rxResetDone   (rxResetDone),
        .mmcmNotLocked (mmcmNotLocked),
        .gtPllLock     (gtPllLock),
        .cpllLock      (cpllLock),
        .powerDown     (powerDown),
        .linkReset     (linkReset),
        .gtReset       (gtReset),
        .txPcsReset    (txPcsReset),
        .txPmaReset    (txPmaReset),
        .txPolarity    (txPolarity)
    );

    task automatic failRun();
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    `include "mgtCsrTasks.svh"

    initial begin
        sysClk = 1'b0;
        forever #(clkPeriod / 2) sysClk = ~sysClk;
    end

    always @(posedge sysClk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            $display("timeout after %0d cycles, the tests did not complete", cycleCount);
            failRun();
        end
    end

    ////////////////////////////////////////////////////////////
    // test sequence

    initial begin
        rst       = 1'b1;
        pSel      = 1'b0;
        pEnable   = 1'b0;
        pWrite    = 1'b0;
        pAddr     = '0;
        pWdata    = '0;
        ctrlModel = '0;
        driveStatus('1);                               // lines busy while in reset
        repeat (4) @(posedge sysClk);
        #driveDelay;
        checkCtrl('0);                                 // still in reset
        checkBit("pSlvErr", 1'b0, pSlvErr);
        rst = 1'b0;
        resetValues();
        ctrlWrites(16);
        statusMapping(16);
        crcQualify();
        badAddress(12);
        backToBack(12);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule : tbMgtCsr
